// ==== m1_config.svh ====
`ifndef M1_CONFIG_SVH
`define M1_CONFIG_SVH

// incoming bus from execute, pc sits in the low word
`define ES_TO_M1_BUS_WD 120
`define ES_PC_LSB       0
`define ES_ALU_LSB      32
`define ES_RT_LSB       64
`define ES_DEST_LSB     96
`define ES_GR_WE_BIT    101
`define ES_LOAD_BIT     102
`define ES_STORE_BIT    103
`define ES_SIZE_LSB     104
`define ES_MFC0_BIT     106
`define ES_MTC0_BIT     107
`define ES_ERET_BIT     108
`define ES_CP0_RD_LSB   109
`define ES_EX_BIT       114
`define ES_EXC_LSB      115

// outgoing bus: ex, load_op, gr_we, dest, final_result, pc
`define M1_TO_MS_BUS_WD 72

`define BADVADDR_NUM    5'd8
`define STATUS_NUM      5'd12
`define CAUSE_NUM       5'd13
`define EPC_NUM         5'd14

`define EXC_INT         5'd0
`define EXC_TLBL        5'd2
`define EXC_TLBS        5'd3
`define EXC_ADEL        5'd4
`define EXC_ADES        5'd5

`define EXC_VECTOR      32'hbfc0_0380

`endif

// ==== m1_pkg.sv ====
`default_nettype none

package m1_pkg;

    // data word, also used for virtual and physical addresses
    typedef logic [31:0] word_t;

    // gpr destination or cp0 register number
    typedef logic [4:0] reg_addr_t;

    typedef logic [4:0] exc_code_t;

    // 0 byte, 1 halfword, 2 word
    typedef logic [1:0] mem_size_t;

    typedef logic [3:0] byte_en_t;

    // physical page number, goes out as the cache tag
    typedef logic [19:0] page_num_t;

endpackage

`default_nettype wire

// ==== m1_op_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface m1_op_if;
    import m1_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     addr;      // alu result, also the memory address
    word_t     rt_value;
    reg_addr_t dest;
    logic      gr_we;
    logic      load;
    logic      store;
    mem_size_t size;
    logic      mfc0;
    logic      mtc0;
    logic      eret;
    reg_addr_t cp0_rd;
    logic      ex_in;     // exception raised upstream
    exc_code_t exc_in;

    modport stage (
        output valid, pc, addr, rt_value, dest, gr_we, load, store, size,
        output mfc0, mtc0, eret, cp0_rd, ex_in, exc_in
    );

    modport request (
        input valid, addr, rt_value, load, store, size, eret, ex_in
    );

    modport commit (
        input valid, pc, addr, rt_value, dest, gr_we, load,
        input mfc0, mtc0, eret, cp0_rd, ex_in, exc_in
    );

endinterface

`default_nettype wire

// ==== m1_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        es_valid,
    input  logic [`ES_TO_M1_BUS_WD-1:0] es_bus,
    output logic                        allowin,
    input  logic                        ready_go,
    input  logic                        ms_allowin,
    input  logic                        flush,
    m1_op_if.stage                      op
);

    logic                        valid;
    logic [`ES_TO_M1_BUS_WD-1:0] bus_r;

    // empty, or the current item leaves this cycle
    assign allowin = !valid || (ready_go && ms_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;  // drop whatever enters behind the flush
        end else if (allowin) begin
            valid <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && allowin) begin
            bus_r <= es_bus;
        end
    end

    assign op.valid    = valid;
    assign op.pc       = bus_r[`ES_PC_LSB +: 32];
    assign op.addr     = bus_r[`ES_ALU_LSB +: 32];
    assign op.rt_value = bus_r[`ES_RT_LSB +: 32];
    assign op.dest     = bus_r[`ES_DEST_LSB +: 5];
    assign op.gr_we    = bus_r[`ES_GR_WE_BIT];
    assign op.load     = bus_r[`ES_LOAD_BIT];
    assign op.store    = bus_r[`ES_STORE_BIT];
    assign op.size     = bus_r[`ES_SIZE_LSB +: 2];
    assign op.mfc0     = bus_r[`ES_MFC0_BIT];
    assign op.mtc0     = bus_r[`ES_MTC0_BIT];
    assign op.eret     = bus_r[`ES_ERET_BIT];
    assign op.cp0_rd   = bus_r[`ES_CP0_RD_LSB +: 5];
    assign op.ex_in    = bus_r[`ES_EX_BIT];  // fetch/decode/execute faults
    assign op.exc_in   = bus_r[`ES_EXC_LSB +: 5];

endmodule

`default_nettype wire

// ==== m1_mem_request.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_mem_request (
    m1_op_if.request          op,
    input  logic              dcache_busy,
    input  logic              ms_allowin,
    output logic              addr_ex,
    output m1_pkg::exc_code_t addr_exc,
    output logic              ready_go,
    output logic              data_valid,
    output logic              data_op,
    output m1_pkg::page_num_t data_tag,
    output logic [7:0]        data_index,
    output logic [3:0]        data_offset,
    output m1_pkg::byte_en_t  data_wstrb,
    output m1_pkg::word_t     data_wdata,
    output m1_pkg::mem_size_t load_size,
    output logic              is_uncache
);
    import m1_pkg::*;

    word_t    paddr;
    byte_en_t strb;
    logic     mem_op;
    logic     kseg0;
    logic     kseg1;
    logic     misaligned;
    logic     no_req;

    assign mem_op = op.load || op.store;
    assign kseg0  = (op.addr[31:29] == 3'b100);
    assign kseg1  = (op.addr[31:29] == 3'b101);
    assign paddr  = {3'b000, op.addr[28:0]};  // unmapped segments drop the top bits

    assign misaligned = ((op.size == 2'd1) && op.addr[0]) ||
                        ((op.size == 2'd2) && (op.addr[1:0] != 2'b00));

    // alignment fault wins over the mapped-region fault
    assign addr_ex  = mem_op && (misaligned || !(kseg0 || kseg1));
    assign addr_exc = misaligned ? (op.store ? `EXC_ADES : `EXC_ADEL)
                                 : (op.store ? `EXC_TLBS : `EXC_TLBL);

    assign no_req   = op.ex_in || op.eret || addr_ex;
    assign ready_go = no_req || !mem_op || !dcache_busy;

    // only issued in the cycle the stage hands the item on
    assign data_valid = op.valid && mem_op && !no_req && !dcache_busy && ms_allowin;

    assign data_op     = op.store;
    assign data_tag    = paddr[31:12];
    assign data_index  = paddr[11:4];
    assign data_offset = paddr[3:0];
    assign load_size   = op.size;
    assign is_uncache  = kseg1;

    always_comb begin
        case (op.size)
            2'd0: begin
                strb       = 4'b0001 << op.addr[1:0];
                data_wdata = {4{op.rt_value[7:0]}};
            end
            2'd1: begin
                strb       = op.addr[1] ? 4'b1100 : 4'b0011;
                data_wdata = {2{op.rt_value[15:0]}};
            end
            default: begin
                strb       = 4'b1111;
                data_wdata = op.rt_value;
            end
        endcase
    end

    assign data_wstrb = (op.store && !no_req) ? strb : 4'b0000;  // loads write nothing

endmodule

`default_nettype wire

// ==== m1_cp0.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_cp0 (
    input  logic              clk,
    input  logic              reset,
    input  logic [5:0]        ext_int,
    input  logic              commit,
    input  logic              exc,
    input  m1_pkg::exc_code_t exc_code,
    input  logic              eret,
    input  logic              mtc0,
    input  m1_pkg::reg_addr_t cp0_rd,
    input  m1_pkg::word_t     wdata,
    input  m1_pkg::word_t     pc,
    input  logic              badvaddr_wr,
    input  m1_pkg::word_t     badvaddr,
    output m1_pkg::word_t     rdata,
    output m1_pkg::word_t     epc,
    output logic              int_pending
);
    import m1_pkg::*;

    logic [7:0] status_im;
    logic       status_exl;
    logic       status_ie;
    logic [7:0] cause_ip;   // [7:2] hardware, [1:0] software
    exc_code_t  cause_exc;
    word_t      epc_r;
    word_t      badvaddr_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            status_im  <= 8'h00;
            status_exl <= 1'b1;
            status_ie  <= 1'b0;
            cause_ip   <= 8'h00;
            cause_exc  <= 5'd0;
            epc_r      <= 32'h0;
            badvaddr_r <= 32'h0;
        end else begin
            cause_ip[7:2] <= ext_int;  // sampled every cycle
            if (commit && exc) begin
                if (!status_exl) begin
                    epc_r <= pc;  // nested fault keeps the first epc
                end
                status_exl <= 1'b1;
                cause_exc  <= exc_code;
                if (badvaddr_wr) begin
                    badvaddr_r <= badvaddr;
                end
            end else if (commit && eret) begin
                status_exl <= 1'b0;
            end else if (commit && mtc0) begin
                case (cp0_rd)
                    `STATUS_NUM: begin
                        status_im  <= wdata[15:8];
                        status_exl <= wdata[1];
                        status_ie  <= wdata[0];
                    end
                    `CAUSE_NUM:    cause_ip[1:0] <= wdata[9:8];
                    `EPC_NUM:      epc_r         <= wdata;
                    `BADVADDR_NUM: badvaddr_r    <= wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (cp0_rd)
            `STATUS_NUM:   rdata = {16'h0, status_im, 6'b0, status_exl, status_ie};
            `CAUSE_NUM:    rdata = {16'h0, cause_ip, 1'b0, cause_exc, 2'b00};
            `EPC_NUM:      rdata = epc_r;
            `BADVADDR_NUM: rdata = badvaddr_r;
            default:       rdata = 32'h0;
        endcase
    end

    assign epc         = epc_r;
    assign int_pending = status_ie && !status_exl && |(cause_ip & status_im);

endmodule

`default_nettype wire

// ==== m1_commit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_commit (
    input  logic                        clk,
    input  logic                        reset,
    m1_op_if.commit                     op,
    input  logic                        addr_ex,
    input  m1_pkg::exc_code_t           addr_exc,
    input  logic                        ready_go,
    input  logic                        ms_allowin,
    input  logic [5:0]                  ext_int,
    output logic                        ms_valid,
    output logic [`M1_TO_MS_BUS_WD-1:0] ms_bus,
    output logic                        fire,
    output logic                        flush,
    output m1_pkg::word_t               flush_pc,
    output m1_pkg::reg_addr_t           fwd_dest,
    output m1_pkg::word_t               fwd_result,
    output logic                        fwd_load,
    output logic                        int_pending
);
    import m1_pkg::*;

    logic      exc;
    exc_code_t exc_code;
    word_t     cp0_rdata;
    word_t     epc;
    word_t     final_result;

    assign exc      = op.ex_in || addr_ex;
    assign exc_code = op.ex_in ? op.exc_in : (addr_ex ? addr_exc : `EXC_INT);

    assign ms_valid = op.valid && ready_go;
    assign fire     = ms_valid && ms_allowin;
    assign flush    = fire && (exc || op.eret);
    assign flush_pc = exc ? `EXC_VECTOR : epc;  // eret returns to epc

    assign final_result = op.mfc0 ? cp0_rdata : op.addr;

    assign ms_bus = {exc, op.load, op.gr_we && !exc, op.dest, final_result, op.pc};

    assign fwd_dest   = op.valid ? op.dest : 5'd0;
    assign fwd_result = final_result;
    assign fwd_load   = op.valid && op.load;

    m1_cp0 m1_cp0_i (
        .clk         (clk),
        .reset       (reset),
        .ext_int     (ext_int),
        .commit      (fire),
        .exc         (exc),
        .exc_code    (exc_code),
        .eret        (op.eret),
        .mtc0        (op.mtc0),
        .cp0_rd      (op.cp0_rd),
        .wdata       (op.rt_value),
        .pc          (op.pc),
        .badvaddr_wr (addr_ex && !op.ex_in),  // only this stage's address faults
        .badvaddr    (op.addr),
        .rdata       (cp0_rdata),
        .epc         (epc),
        .int_pending (int_pending)
    );

endmodule

`default_nettype wire

// ==== m1_stage_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_stage_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        es_valid,
    input  logic [`ES_TO_M1_BUS_WD-1:0] es_bus,
    output logic                        allowin,
    output logic                        ms_valid,
    output logic [`M1_TO_MS_BUS_WD-1:0] ms_bus,
    input  logic                        ms_allowin,
    input  logic [5:0]                  ext_int,
    output logic                        data_valid,
    output logic                        data_op,
    output m1_pkg::page_num_t           data_tag,
    output logic [7:0]                  data_index,
    output logic [3:0]                  data_offset,
    output m1_pkg::byte_en_t            data_wstrb,
    output m1_pkg::word_t               data_wdata,
    output m1_pkg::mem_size_t           load_size,
    output logic                        is_uncache,
    input  logic                        dcache_busy,
    output m1_pkg::reg_addr_t           fwd_dest,
    output m1_pkg::word_t               fwd_result,
    output logic                        fwd_load,
    output logic                        flush,
    output m1_pkg::word_t               flush_pc,
    output logic                        int_pending
);
    import m1_pkg::*;

    logic      ready_go;
    logic      addr_ex;
    exc_code_t addr_exc;

    m1_op_if op ();

    m1_decode m1_decode_i (
        .clk        (clk),
        .reset      (reset),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .allowin    (allowin),
        .ready_go   (ready_go),
        .ms_allowin (ms_allowin),
        .flush      (flush),
        .op         (op.stage)
    );

    m1_mem_request m1_mem_request_i (
        .op          (op.request),
        .dcache_busy (dcache_busy),
        .ms_allowin  (ms_allowin),
        .addr_ex     (addr_ex),
        .addr_exc    (addr_exc),
        .ready_go    (ready_go),
        .data_valid  (data_valid),
        .data_op     (data_op),
        .data_tag    (data_tag),
        .data_index  (data_index),
        .data_offset (data_offset),
        .data_wstrb  (data_wstrb),
        .data_wdata  (data_wdata),
        .load_size   (load_size),
        .is_uncache  (is_uncache)
    );

    m1_commit m1_commit_i (
        .clk         (clk),
        .reset       (reset),
        .op          (op.commit),
        .addr_ex     (addr_ex),
        .addr_exc    (addr_exc),
        .ready_go    (ready_go),
        .ms_allowin  (ms_allowin),
        .ext_int     (ext_int),
        .ms_valid    (ms_valid),
        .ms_bus      (ms_bus),
        .fire        (),  // allowin already covers the handoff
        .flush       (flush),
        .flush_pc    (flush_pc),
        .fwd_dest    (fwd_dest),
        .fwd_result  (fwd_result),
        .fwd_load    (fwd_load),
        .int_pending (int_pending)
    );

endmodule

`default_nettype wire

// ==== m1_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module m1_checker (
    input logic                        clk,
    input logic                        reset,
    input logic                        allowin,
    input logic                        ms_valid,
    input logic [`M1_TO_MS_BUS_WD-1:0] ms_bus,
    input logic                        ms_allowin,
    input logic                        dcache_busy,
    input logic                        data_valid,
    input logic                        data_op,
    input m1_pkg::page_num_t           data_tag,
    input logic [7:0]                  data_index,
    input logic [3:0]                  data_offset,
    input m1_pkg::byte_en_t            data_wstrb,
    input m1_pkg::word_t               data_wdata,
    input m1_pkg::mem_size_t           load_size,
    input logic                        is_uncache,
    input m1_pkg::reg_addr_t           fwd_dest,
    input m1_pkg::word_t               fwd_result,
    input logic                        fwd_load,
    input logic                        flush,
    input m1_pkg::word_t               flush_pc,
    input logic                        int_pending
);
    import m1_pkg::*;

    logic [`M1_TO_MS_BUS_WD-1:0] bus_q[$];
    logic [32:0]                 ctl_q[$];  // flush, flush_pc
    logic [72:0]                 req_q[$];  // request expected, then its fields
    logic [`M1_TO_MS_BUS_WD-1:0] e_bus;
    logic [32:0]                 e_ctl;
    logic [72:0]                 e_req;
    logic                        e_ready;
    logic                        e_op;
    page_num_t                   e_tag;
    logic [7:0]                  e_index;
    logic [3:0]                  e_offset;
    byte_en_t                    e_wstrb;
    word_t                       e_wdata;
    mem_size_t                   e_size;
    logic                        e_uncache;
    int                          errors = 0;
    int                          checks = 0;

    task automatic expect_item(input logic [71:0] bus, input logic [32:0] ctl,
                               input logic [72:0] req);
        bus_q.push_back(bus);
        ctl_q.push_back(ctl);
        req_q.push_back(req);
    endtask

    function automatic int pending_count();
        return bus_q.size();
    endfunction

    task automatic compare_value(input string name, input logic [71:0] got,
                                 input logic [71:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s got %0h expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    task automatic check_idle();
        compare_value("ms_valid", ms_valid, 1'b0);
        compare_value("data_valid", data_valid, 1'b0);
        compare_value("flush", flush, 1'b0);
        compare_value("int_pending", int_pending, 1'b0);
    endtask

    task automatic check_int_pending(input logic exp);
        compare_value("int_pending", int_pending, exp);
    endtask

    // forwarding reflects the held item, dest and result fields of its bus
    task automatic watch_forwarding();
        logic [`M1_TO_MS_BUS_WD-1:0] head;
        head = bus_q[0];
        compare_value("fwd_dest", fwd_dest, head[68:64]);
        compare_value("fwd_result", fwd_result, head[63:32]);
        compare_value("fwd_load", fwd_load, head[70]);
    endtask

    task automatic take_transfer();
        e_bus = bus_q.pop_front();
        e_ctl = ctl_q.pop_front();
        e_req = req_q.pop_front();
        compare_value("ms_bus", ms_bus, e_bus);
        compare_value("flush", flush, e_ctl[32]);
        if (e_ctl[32]) begin
            compare_value("flush_pc", flush_pc, e_ctl[31:0]);
        end
        compare_value("data_valid", data_valid, e_req[72]);
        if (e_req[72]) begin
            {e_op, e_tag, e_index, e_offset, e_wstrb, e_wdata, e_size, e_uncache} = e_req[71:0];
            compare_value("data_op", data_op, e_op);
            compare_value("data_tag", data_tag, e_tag);
            compare_value("data_index", data_index, e_index);
            compare_value("data_offset", data_offset, e_offset);
            compare_value("data_wstrb", data_wstrb, e_wstrb);
            compare_value("data_wdata", data_wdata, e_wdata);
            compare_value("load_size", load_size, e_size);
            compare_value("is_uncache", is_uncache, e_uncache);
        end
    endtask

    // inputs settle 1 ns after the edge, so the falling edge sees final values
    always @(negedge clk) begin
        if (!reset) begin
            if (bus_q.size() == 0) begin
                if (ms_valid) begin
                    report_problem("stage offered an item that was never sent or already left");
                end
                compare_value("allowin", allowin, 1'b1);  // stage empty
                compare_value("fwd_dest", fwd_dest, 5'd0);
            end else begin
                e_ready = !(req_q[0][72] && dcache_busy);  // only a live request waits
                watch_forwarding();
                compare_value("ms_valid", ms_valid, e_ready);
                compare_value("allowin", allowin, e_ready && ms_allowin);
                if (ms_valid && ms_allowin) begin
                    take_transfer();
                end
            end
            if ((data_valid || flush) && !(ms_valid && ms_allowin)) begin
                report_problem("cache request or flush raised without a transfer");
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_m1_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "m1_config.svh"

module tb_m1_stage;
    import m1_pkg::*;

    localparam int    NUM_ROWS       = 24;
    localparam int    RESET_CYCLES   = 10;
    localparam int    TIMEOUT_CYCLES = 40 * NUM_ROWS + RESET_CYCLES;
    localparam int    MASK_ROW       = 22;  // interrupt is raised before this row
    localparam word_t PC_BASE        = 32'hbfc0_0000;

    localparam logic [2:0] K_ALU  = 3'd0;
    localparam logic [2:0] K_LD   = 3'd1;
    localparam logic [2:0] K_ST   = 3'd2;
    localparam logic [2:0] K_MTC0 = 3'd3;
    localparam logic [2:0] K_MFC0 = 3'd4;
    localparam logic [2:0] K_ERET = 3'd5;

    typedef struct packed {
        logic [2:0] kind;
        word_t      addr;
        word_t      rt;
        mem_size_t  size;
        reg_addr_t  dest;
        reg_addr_t  cp0;
        logic [3:0] busy;
        logic [3:0] stall;
        word_t      exp;   // mfc0 read value or eret target
    } row_t;

    row_t rows [NUM_ROWS];

    logic                        clk;
    logic                        reset;
    logic                        es_valid;
    logic [`ES_TO_M1_BUS_WD-1:0] es_bus;
    logic                        allowin;
    logic                        ms_valid;
    logic [`M1_TO_MS_BUS_WD-1:0] ms_bus;
    logic                        ms_allowin;
    logic [5:0]                  ext_int;
    logic                        data_valid;
    logic                        data_op;
    page_num_t                   data_tag;
    logic [7:0]                  data_index;
    logic [3:0]                  data_offset;
    byte_en_t                    data_wstrb;
    word_t                       data_wdata;
    mem_size_t                   load_size;
    logic                        is_uncache;
    logic                        dcache_busy;
    reg_addr_t                   fwd_dest;
    word_t                       fwd_result;
    logic                        fwd_load;
    logic                        flush;
    word_t                       flush_pc;
    logic                        int_pending;

    int   busy_left;
    int   stall_left;
    int   cycles;
    logic prev_flush;

    m1_stage_top m1_stage_top_i (.*);

    m1_checker m1_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fill_rows();
        rows[0]  = '{K_ALU,  32'h1234_5678, 32'h0, 2'd0, 5'd4, 5'd0, 4'd0, 4'd2, 32'h0};
        rows[1]  = '{K_LD,   32'h8000_1234, 32'h0, 2'd2, 5'd5, 5'd0, 4'd2, 4'd0, 32'h0};
        rows[2]  = '{K_ST,   32'ha000_2345, 32'hab, 2'd0, 5'd0, 5'd0, 4'd1, 4'd1, 32'h0};
        rows[3]  = '{K_LD,   32'ha010_0ff6, 32'h0, 2'd1, 5'd6, 5'd0, 4'd0, 4'd0, 32'h0};
        rows[4]  = '{K_ST,   32'h9abc_def2, 32'h1234_5678, 2'd1, 5'd0, 5'd0, 4'd3, 4'd0, 32'h0};
        rows[5]  = '{K_ST,   32'h8765_4320, 32'hdead_beef, 2'd2, 5'd0, 5'd0, 4'd0, 4'd1, 32'h0};
        rows[6]  = '{K_LD,   32'h8000_0003, 32'h0, 2'd0, 5'd7, 5'd0, 4'd1, 4'd2, 32'h0};
        rows[7]  = '{K_MTC0, 32'h0, 32'h0, 2'd0, 5'd0, `STATUS_NUM, 4'd0, 4'd0, 32'h0};
        rows[8]  = '{K_LD,   32'h8000_0102, 32'h0, 2'd2, 5'd9, 5'd0, 4'd2, 4'd0, 32'h0};
        rows[9]  = '{K_ALU,  32'h0bad_0bad, 32'h0, 2'd0, 5'd10, 5'd0, 4'd0, 4'd0, 32'h0};
        rows[10] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd11, `EPC_NUM, 4'd0, 4'd1, 32'hbfc0_0020};
        rows[11] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd12, `CAUSE_NUM, 4'd0, 4'd0, 32'h10};
        rows[12] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd13, `BADVADDR_NUM, 4'd0, 4'd0,
                     32'h8000_0102};
        rows[13] = '{K_MTC0, 32'h0, 32'h0, 2'd0, 5'd0, `STATUS_NUM, 4'd0, 4'd0, 32'h0};
        rows[14] = '{K_ST,   32'h0040_0000, 32'h1111_1111, 2'd2, 5'd0, 5'd0, 4'd1, 4'd1, 32'h0};
        rows[15] = '{K_ALU,  32'h0bad_0bad, 32'h0, 2'd0, 5'd10, 5'd0, 4'd0, 4'd0, 32'h0};
        rows[16] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd14, `CAUSE_NUM, 4'd0, 4'd0, 32'hc};
        rows[17] = '{K_MTC0, 32'h0, 32'hbfc0_1000, 2'd0, 5'd0, `EPC_NUM, 4'd0, 4'd0, 32'h0};
        rows[18] = '{K_ERET, 32'h0, 32'h0, 2'd0, 5'd0, 5'd0, 4'd0, 4'd1, 32'hbfc0_1000};
        rows[19] = '{K_ALU,  32'h0bad_0bad, 32'h0, 2'd0, 5'd10, 5'd0, 4'd0, 4'd0, 32'h0};
        rows[20] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd15, `STATUS_NUM, 4'd0, 4'd0, 32'h0};
        rows[21] = '{K_MTC0, 32'h0, 32'h0401, 2'd0, 5'd0, `STATUS_NUM, 4'd0, 4'd0, 32'h0};
        rows[22] = '{K_MTC0, 32'h0, 32'h0001, 2'd0, 5'd0, `STATUS_NUM, 4'd0, 4'd0, 32'h0};
        rows[23] = '{K_MFC0, 32'h0, 32'h0, 2'd0, 5'd16, `STATUS_NUM, 4'd0, 4'd0, 32'h1};
    endtask

    function automatic logic writes_gpr(input logic [2:0] kind);
        return (kind == K_ALU) || (kind == K_LD) || (kind == K_MFC0);
    endfunction

    function automatic logic [`ES_TO_M1_BUS_WD-1:0] pack_bus(input row_t r, input int idx);
        word_t pc;
        pc = PC_BASE + 32'(4 * idx);
        return {5'd0, 1'b0, r.cp0, r.kind == K_ERET, r.kind == K_MTC0, r.kind == K_MFC0,
                r.size, r.kind == K_ST, r.kind == K_LD, writes_gpr(r.kind), r.dest,
                r.rt, r.addr, pc};
    endfunction

    task automatic push_expected(input row_t r, input int idx, output logic flushes);
        logic     mem;
        logic     store;
        logic     misaligned;
        logic     fault;
        int       nbytes;
        word_t    pc;
        word_t    paddr;
        word_t    wdata;
        word_t    result;
        byte_en_t strb;
        pc         = PC_BASE + 32'(4 * idx);
        store      = (r.kind == K_ST);
        mem        = store || (r.kind == K_LD);
        nbytes     = 1 << r.size;
        misaligned = (r.addr[1:0] % nbytes) != 0;  // natural alignment
        fault      = mem && (misaligned || (r.addr[31:30] != 2'b10));  // kseg0 or kseg1 only
        flushes    = fault || (r.kind == K_ERET);
        paddr      = {3'b000, r.addr[28:0]};
        result     = (r.kind == K_MFC0) ? r.exp : r.addr;
        // lanes inside the addressed chunk, rt repeated once per chunk
        for (int b = 0; b < 4; b++) begin
            strb[b]         = store && ((b / nbytes) == (r.addr[1:0] / nbytes));
            wdata[8*b +: 8] = r.rt[8*(b % nbytes) +: 8];
        end
        m1_checker_i.expect_item(
            {fault, r.kind == K_LD, writes_gpr(r.kind) && !fault, r.dest, result, pc},
            {flushes, fault ? `EXC_VECTOR : r.exp},
            {mem && !fault, store, paddr[31:12], paddr[11:4], paddr[3:0], strb, wdata,
             r.size, r.addr[29]});
    endtask

    // cache busy first, then next stage stalls, for the item held
    task automatic drive_hold();
        dcache_busy = (busy_left > 0);
        ms_allowin  = (busy_left > 0) || (stall_left == 0);
        if (busy_left > 0) begin
            busy_left--;
        end else if (stall_left > 0) begin
            stall_left--;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            drive_hold();
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_stage();
        es_valid = 1'b0;
        while (m1_checker_i.pending_count() != 0) begin
            wait_cycles(1);
        end
    endtask

    task automatic apply_row(input int idx);
        logic taken;
        logic flushes;
        taken    = 1'b0;
        es_valid = 1'b1;
        es_bus   = pack_bus(rows[idx], idx);
        while (!taken) begin
            drive_hold();
            @(negedge clk);
            taken = allowin;
            @(posedge clk);
            #1;
        end
        if (prev_flush) begin
            prev_flush = 1'b0;  // entered with the flush, so dropped
        end else begin
            push_expected(rows[idx], idx, flushes);
            prev_flush = flushes;
        end
        busy_left  = rows[idx].busy + ($urandom % 2);
        stall_left = rows[idx].stall;
    endtask

    task automatic raise_interrupt();
        drain_stage();
        wait_cycles(2);
        m1_checker_i.check_int_pending(1'b0);  // IE and IM set, line still quiet
        ext_int = 6'b000001;
        wait_cycles(2);
        m1_checker_i.check_int_pending(1'b1);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, an item never left the stage", cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int unsigned seed_init;
        seed_init   = $urandom(99);
        reset       = 1'b1;
        es_valid    = 1'b0;
        es_bus      = '0;
        ms_allowin  = 1'b1;
        dcache_busy = 1'b0;
        ext_int     = 6'b0;
        busy_left   = 0;
        stall_left  = 0;
        prev_flush  = 1'b0;
        fill_rows();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        m1_checker_i.check_idle();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (i == MASK_ROW) begin
                raise_interrupt();
            end
            apply_row(i);
        end
        drain_stage();
        wait_cycles(2);
        m1_checker_i.check_int_pending(1'b0);  // masked by IM
        $display("%0d checks, %0d errors", m1_checker_i.checks, m1_checker_i.errors);
        if (m1_checker_i.errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== m1_stage_top.f ====
+incdir+.
m1_pkg.sv
m1_op_if.sv
m1_decode.sv
m1_mem_request.sv
m1_cp0.sv
m1_commit.sv
m1_stage_top.sv
m1_checker.sv
tb_m1_stage.sv
